//--- hw/ecg_pkg.sv
/*
 * Shared constants and types for the ECG output stage of the block-prediction
 * entropy encoder. Every RTL block imports what it needs from here, so field
 * widths and limits are changed in this one place only
 */

package ecg_pkg;

	// ========================================
	// Field widths and limits
	// ========================================

	localparam int ECG_W_DEFAULT = 50;   // Default width of the packed ECG word
	localparam int BITS_REQ_W    = 4;    // Width of bits_req
	localparam int CPEC_MIN_BITS = 3;    // bits_req at or above this selects CPEC
	localparam int CPEC_MAX_BITS = 9;    // Largest bits_req a CPEC group may carry
	localparam int CPEC_SAMPLES  = 4;    // Samples per CPEC group
	localparam int CPEC_CODE_W   = 36;   // CPEC_SAMPLES times CPEC_MAX_BITS

	localparam int VEC_PREFIX_W  = 7;
	localparam int VEC_SUFFIX_W  = 5;

	localparam int STUFF_SIZE_W  = 5;
	localparam int STUFF_MAX     = 17;   // Longest stuffing run the rate control asks for

	localparam int SIGN_W        = 12;
	localparam int SIGN_SIZE_W   = 4;

	// Worst-case total: flag, unary prefix and CPEC code, then stuffing and signs
	localparam int ECG_MAX_SUM = 1 + (1 + CPEC_SAMPLES) * CPEC_MAX_BITS + STUFF_MAX + SIGN_W;

	// Wide enough for every legal sum (75 needs 7 bits)
	localparam int ECG_SIZE_W = $clog2(ECG_MAX_SUM + 1);

	// ========================================
	// Types
	// ========================================

	typedef logic [ECG_SIZE_W-1:0] ecg_size_t;   // Bit count of a field or of the whole ECG

	// Coding mode of the data field
	typedef enum logic [1:0] {
		MODE_IDLE = 2'd0,   // Data not active, no data field at all
		MODE_SKIP = 2'd1,   // Group skip, a single one
		MODE_CPEC = 2'd2,   // Zero flag, unary prefix, fixed-length samples
		MODE_VEC  = 2'd3    // Zero flag, unary prefix, VEC prefix and suffix
	} ecg_mode_e;

endpackage

//--- hw/ecg_input_stage.sv
/*
 * First pipe stage of the ECG output. Samples one group's fields on in_valid,
 * decodes its coding mode and whether stuffing and sign fields are present,
 * and hands the registered group to the data builder and the packer
 */

`timescale 1ns/1ns

module ecg_input_stage
(
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               in_valid,
	input  logic                               data_active,
	input  logic                               group_skip,
	input  logic                               component_skip,
	input  logic                               underflow_prevention,
	input  logic [1:0]                         ecg_idx,
	input  logic [ecg_pkg::BITS_REQ_W-1:0]     bits_req,
	input  logic [ecg_pkg::CPEC_CODE_W-1:0]    cpec_code,
	input  logic [ecg_pkg::VEC_PREFIX_W-1:0]   vec_prefix,
	input  logic [2:0]                         vec_prefix_size,
	input  logic [ecg_pkg::VEC_SUFFIX_W-1:0]   vec_suffix,
	input  logic [2:0]                         vec_suffix_size,
	input  logic [ecg_pkg::SIGN_W-1:0]         sign_bits,
	input  logic [ecg_pkg::SIGN_SIZE_W-1:0]    sign_size,
	input  logic [ecg_pkg::STUFF_SIZE_W-1:0]   stuff_size,
	output logic                               grp_valid,
	output ecg_pkg::ecg_mode_e                 mode,
	output logic                               sign_present,
	output logic                               stuff_present,
	output logic [ecg_pkg::BITS_REQ_W-1:0]     bits_req_q,
	output logic [ecg_pkg::CPEC_CODE_W-1:0]    cpec_code_q,
	output logic [ecg_pkg::VEC_PREFIX_W-1:0]   vec_prefix_q,
	output logic [2:0]                         vec_prefix_size_q,
	output logic [ecg_pkg::VEC_SUFFIX_W-1:0]   vec_suffix_q,
	output logic [2:0]                         vec_suffix_size_q,
	output logic [ecg_pkg::SIGN_W-1:0]         sign_bits_q,
	output logic [ecg_pkg::SIGN_SIZE_W-1:0]    sign_size_q,
	output logic [ecg_pkg::STUFF_SIZE_W-1:0]   stuff_size_q
);

	import ecg_pkg::*;

	ecg_mode_e next_mode;   // Mode decoded from the raw control inputs
	logic      sign_sel;
	logic      stuff_sel;

	// ========================================
	// Mode and presence decode
	// ========================================

	always_comb
	begin
		// Priority is data_active, then group skip, then the CPEC/VEC split
		if (!data_active)
			next_mode = MODE_IDLE;
		else if (group_skip)
			next_mode = MODE_SKIP;
		else if (bits_req >= BITS_REQ_W'(CPEC_MIN_BITS))
			next_mode = MODE_CPEC;   // Large residuals go out as fixed-length samples
		else
			next_mode = MODE_VEC;

		sign_sel  = (ecg_idx == 2'd3) && !component_skip;            // Signs close the last ECG
		stuff_sel = (ecg_idx != 2'd0) && underflow_prevention;      // No stuffing in ECG 0
	end

	// Strobe and decoded control
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			grp_valid     <= 1'b0;
			mode          <= MODE_IDLE;
			sign_present  <= 1'b0;
			stuff_present <= 1'b0;
		end
		else
		begin
			grp_valid <= in_valid;   // High for one cycle per sampled group
			if (in_valid)
			begin
				mode          <= next_mode;
				sign_present  <= sign_sel;
				stuff_present <= stuff_sel;
			end
		end
	end

	// Field values are only looked at while the group's control is valid
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			bits_req_q        <= bits_req;
			cpec_code_q       <= cpec_code;
			vec_prefix_q      <= vec_prefix;
			vec_prefix_size_q <= vec_prefix_size;
			vec_suffix_q      <= vec_suffix;
			vec_suffix_size_q <= vec_suffix_size;
			sign_bits_q       <= sign_bits;
			sign_size_q       <= sign_size;
			stuff_size_q      <= stuff_size;
		end
	end

endmodule

//--- hw/ecg_data_builder.sv
/*
 * Builds the data field of one ECG, left-aligned in an ECG_W word, together
 * with its size. Purely combinational; the packer appends stuffing and signs
 * behind it. Every subfield is placed by a shift that is computed from the
 * sizes of the subfields in front of it
 */

`timescale 1ns/1ns

module ecg_data_builder
#(
	parameter int ECG_W = ecg_pkg::ECG_W_DEFAULT
)
(
	input  ecg_pkg::ecg_mode_e                 mode,
	input  logic [ecg_pkg::BITS_REQ_W-1:0]     bits_req,
	input  logic [ecg_pkg::CPEC_CODE_W-1:0]    cpec_code,
	input  logic [ecg_pkg::VEC_PREFIX_W-1:0]   vec_prefix,
	input  logic [2:0]                         vec_prefix_size,
	input  logic [ecg_pkg::VEC_SUFFIX_W-1:0]   vec_suffix,
	input  logic [2:0]                         vec_suffix_size,
	output logic [ECG_W-1:0]                   data_field,
	output ecg_pkg::ecg_size_t                 data_size
);

	import ecg_pkg::*;

	// Moves the low len bits of value to the top of the word, MSB first
	function automatic logic [ECG_W-1:0] left_align(input logic [ECG_W-1:0] value,
		input ecg_size_t len);
		logic [ECG_W-1:0] mask;
		mask = ~({ECG_W{1'b1}} << len);   // len ones at the bottom
		return (value & mask) << (ECG_W - len);
	endfunction

	ecg_size_t        req_len;       // bits_req widened to the size type
	ecg_size_t        unary_ones;    // Ones in the unary prefix, one less than bits_req
	ecg_size_t        cpec_len;      // Total bits of the CPEC samples
	ecg_size_t        pre_len;
	ecg_size_t        suf_len;
	logic [ECG_W-1:0] unary_part;
	logic [ECG_W-1:0] cpec_part;
	logic [ECG_W-1:0] prefix_part;
	logic [ECG_W-1:0] suffix_part;

	// ========================================
	// Subfields at their offsets
	// ========================================

	always_comb
	begin
		req_len = ecg_size_t'(bits_req);
		pre_len = ecg_size_t'(vec_prefix_size);
		suf_len = ecg_size_t'(vec_suffix_size);

		// bits_req of zero gives an empty prefix in VEC
		unary_ones = (req_len == '0) ? '0 : req_len - 1'b1;

		// Code length follows from bits_req, no separate size input is needed
		cpec_len = ecg_size_t'(CPEC_SAMPLES) * req_len;

		// Unary prefix sits right behind the zero flag, its closing zero comes for free
		unary_part = ~({ECG_W{1'b1}} >> unary_ones) >> 1;

		// Samples, and the VEC prefix, start after flag plus unary prefix
		cpec_part   = left_align(ECG_W'(cpec_code), cpec_len) >> (req_len + 1'b1);
		prefix_part = left_align(ECG_W'(vec_prefix), pre_len) >> (req_len + 1'b1);

		// VEC suffix goes behind the VEC prefix
		suffix_part = left_align(ECG_W'(vec_suffix), suf_len) >> (req_len + pre_len + 1'b1);
	end

	// ========================================
	// Field select by mode
	// ========================================

	always_comb
	begin
		case (mode)
			MODE_SKIP:
			begin
				data_field = {1'b1, {(ECG_W-1){1'b0}}};   // Group-skip flag only
				data_size  = ecg_size_t'(1);
			end
			MODE_CPEC:
			begin
				data_field = unary_part | cpec_part;      // MSB stays zero as the flag
				data_size  = req_len + cpec_len + 1'b1;
			end
			MODE_VEC:
			begin
				data_field = unary_part | prefix_part | suffix_part;
				data_size  = req_len + pre_len + suf_len + 1'b1;
			end
			default:
			begin
				// Idle, the ECG carries no data field
				data_field = '0;
				data_size  = '0;
			end
		endcase
	end

endmodule

//--- hw/ecg_packer.sv
/*
 * Last pipe stage of the ECG output. Appends the stuffing run and the sign
 * bits behind the data field, totals the sizes of the fields present and
 * registers word, size and strobe when a group is valid
 */

`timescale 1ns/1ns

module ecg_packer
#(
	parameter int ECG_W = ecg_pkg::ECG_W_DEFAULT
)
(
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               grp_valid,
	input  logic                               sign_present,
	input  logic                               stuff_present,
	input  logic [ECG_W-1:0]                   data_field,
	input  ecg_pkg::ecg_size_t                 data_size,
	input  logic [ecg_pkg::STUFF_SIZE_W-1:0]   stuff_size,
	input  logic [ecg_pkg::SIGN_W-1:0]         sign_bits,
	input  logic [ecg_pkg::SIGN_SIZE_W-1:0]    sign_size,
	output logic                               out_valid,
	output logic [ECG_W-1:0]                   encoded_ecg,
	output ecg_pkg::ecg_size_t                 ecg_size
);

	import ecg_pkg::*;

	ecg_size_t        stuff_len;     // Zero when no stuffing in this ECG
	ecg_size_t        sign_len;      // Zero when no signs in this ECG
	ecg_size_t        total_size;
	logic [ECG_W-1:0] sign_mask;
	logic [ECG_W-1:0] stuff_field;
	logic [ECG_W-1:0] sign_field;

	// ========================================
	// Stuffing and sign placement
	// ========================================

	always_comb
	begin
		stuff_len = stuff_present ? ecg_size_t'(stuff_size) : '0;
		sign_len  = sign_present ? ecg_size_t'(sign_size) : '0;

		// Run of ones at the top, then moved behind the data field
		stuff_field = ~({ECG_W{1'b1}} >> stuff_len) >> data_size;

		// Low sign_len sign bits are left-aligned first, then moved behind the stuffing
		sign_mask  = ~({ECG_W{1'b1}} << sign_len);
		sign_field = ((ECG_W'(sign_bits) & sign_mask) << (ECG_W - sign_len))
			>> (data_size + stuff_len);

		// Absent fields already count zero here
		total_size = data_size + stuff_len + sign_len;
	end

	// Output register, holds its value between strobes
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid   <= 1'b0;
			encoded_ecg <= '0;
			ecg_size    <= '0;
		end
		else
		begin
			out_valid <= grp_valid;
			if (grp_valid)
			begin
				encoded_ecg <= data_field | stuff_field | sign_field;   // Fields never overlap
				ecg_size    <= total_size;
			end
		end
	end

endmodule

//--- hw/ecg_final_output.sv
/*
 * Top level of the ECG output stage. A group strobed in with in_valid comes
 * out two cycles later as a left-aligned ECG word with its used size. A new
 * group may enter every cycle
 */

`timescale 1ns/1ns

module ecg_final_output
#(
	parameter int ECG_W = ecg_pkg::ECG_W_DEFAULT
)
(
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               in_valid,
	input  logic                               data_active,
	input  logic                               group_skip,
	input  logic [1:0]                         ecg_idx,
	input  logic                               component_skip,
	input  logic                               underflow_prevention,
	input  logic [ecg_pkg::BITS_REQ_W-1:0]     bits_req,
	input  logic [ecg_pkg::CPEC_CODE_W-1:0]    cpec_code,
	input  logic [ecg_pkg::VEC_PREFIX_W-1:0]   vec_prefix,
	input  logic [2:0]                         vec_prefix_size,
	input  logic [ecg_pkg::VEC_SUFFIX_W-1:0]   vec_suffix,
	input  logic [2:0]                         vec_suffix_size,
	input  logic [ecg_pkg::SIGN_W-1:0]         sign_bits,
	input  logic [ecg_pkg::SIGN_SIZE_W-1:0]    sign_size,
	input  logic [ecg_pkg::STUFF_SIZE_W-1:0]   stuff_size,
	output logic                               out_valid,
	output logic [ECG_W-1:0]                   encoded_ecg,
	output ecg_pkg::ecg_size_t                 ecg_size
);

	import ecg_pkg::*;

	// ========================================
	// Registered group
	// ========================================

	logic                      grp_valid;
	ecg_mode_e                 mode;
	logic                      sign_present;
	logic                      stuff_present;
	logic [BITS_REQ_W-1:0]     bits_req_q;
	logic [CPEC_CODE_W-1:0]    cpec_code_q;
	logic [VEC_PREFIX_W-1:0]   vec_prefix_q;
	logic [2:0]                vec_prefix_size_q;
	logic [VEC_SUFFIX_W-1:0]   vec_suffix_q;
	logic [2:0]                vec_suffix_size_q;
	logic [SIGN_W-1:0]         sign_bits_q;
	logic [SIGN_SIZE_W-1:0]    sign_size_q;
	logic [STUFF_SIZE_W-1:0]   stuff_size_q;

	// Data field, same cycle as the registered group
	logic [ECG_W-1:0]          data_field;
	ecg_size_t                 data_size;

	ecg_input_stage u_input_stage
	(
		.clk                  (clk),
		.rst                  (rst),
		.in_valid             (in_valid),
		.data_active          (data_active),
		.group_skip           (group_skip),
		.component_skip       (component_skip),
		.underflow_prevention (underflow_prevention),
		.ecg_idx              (ecg_idx),
		.bits_req             (bits_req),
		.cpec_code            (cpec_code),
		.vec_prefix           (vec_prefix),
		.vec_prefix_size      (vec_prefix_size),
		.vec_suffix           (vec_suffix),
		.vec_suffix_size      (vec_suffix_size),
		.sign_bits            (sign_bits),
		.sign_size            (sign_size),
		.stuff_size           (stuff_size),
		.grp_valid            (grp_valid),
		.mode                 (mode),
		.sign_present         (sign_present),
		.stuff_present        (stuff_present),
		.bits_req_q           (bits_req_q),
		.cpec_code_q          (cpec_code_q),
		.vec_prefix_q         (vec_prefix_q),
		.vec_prefix_size_q    (vec_prefix_size_q),
		.vec_suffix_q         (vec_suffix_q),
		.vec_suffix_size_q    (vec_suffix_size_q),
		.sign_bits_q          (sign_bits_q),
		.sign_size_q          (sign_size_q),
		.stuff_size_q         (stuff_size_q)
	);

	ecg_data_builder #(.ECG_W(ECG_W)) u_data_builder
	(
		.mode            (mode),
		.bits_req        (bits_req_q),
		.cpec_code       (cpec_code_q),
		.vec_prefix      (vec_prefix_q),
		.vec_prefix_size (vec_prefix_size_q),
		.vec_suffix      (vec_suffix_q),
		.vec_suffix_size (vec_suffix_size_q),
		.data_field      (data_field),
		.data_size       (data_size)
	);

	// Output register sits in here, second cycle of the pipe
	ecg_packer #(.ECG_W(ECG_W)) u_packer
	(
		.clk           (clk),
		.rst           (rst),
		.grp_valid     (grp_valid),
		.sign_present  (sign_present),
		.stuff_present (stuff_present),
		.data_field    (data_field),
		.data_size     (data_size),
		.stuff_size    (stuff_size_q),
		.sign_bits     (sign_bits_q),
		.sign_size     (sign_size_q),
		.out_valid     (out_valid),
		.encoded_ecg   (encoded_ecg),
		.ecg_size      (ecg_size)
	);

endmodule

//--- testbench/ecg_ref_model.svh
/*
 * Reference model for the ECG output testbench. Builds the expected ECG word
 * bit by bit from the field rules and holds the stimulus LFSR. Included inside
 * the testbench module after ECG_W and the package import
 */

`ifndef ECG_REF_MODEL_SVH
`define ECG_REF_MODEL_SVH

logic [31:0] lfsr_state = 32'hef4974fc;   // Stimulus LFSR, one step per bit taken

// Steps the Fibonacci LFSR once per bit and collects each new bit
function automatic logic [63:0] take_bits(input int n);
	logic [63:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};   // Taps for x^32 + x^22 + x^2 + x + 1
		r          = {r[62:0], fb};
	end
	return r;
endfunction

// Appends the low len bits of val at bit position pos, counted from the MSB
function automatic void append_bits(inout logic [ECG_W-1:0] word, inout int pos,
	input logic [63:0] val, input int len);
	for (int i = len - 1; i >= 0; i--)
	begin
		if (pos < ECG_W)
			word[ECG_W-1-pos] = val[i];   // Past the LSB only the count moves on
		pos++;
	end
endfunction

// Expected word and size of one group, fields in order data, stuffing, signs
function automatic void expect_ecg(input logic act, input logic skip,
	input logic [1:0] idx, input logic cskip, input logic uflow, input int req,
	input logic [63:0] code, input logic [63:0] pre, input int pre_len,
	input logic [63:0] suf, input int suf_len, input logic [63:0] sign,
	input int sign_len, input int stuff_len, output logic [ECG_W-1:0] word,
	output int size);
	int pos;
	word = '0;
	pos  = 0;
	if (act && skip)
		append_bits(word, pos, 64'd1, 1);   // Group-skip flag is the whole field
	else if (act)
	begin
		append_bits(word, pos, 64'd0, 1);
		for (int i = 1; i < req; i++)
			append_bits(word, pos, 64'd1, 1);
		if (req > 0)
			append_bits(word, pos, 64'd0, 1);   // Unary prefix ends in a zero
		if (req >= CPEC_MIN_BITS)
			append_bits(word, pos, code, CPEC_SAMPLES * req);
		else
		begin
			append_bits(word, pos, pre, pre_len);
			append_bits(word, pos, suf, suf_len);
		end
	end
	if (idx != 2'd0 && uflow)
		append_bits(word, pos, {64{1'b1}}, stuff_len);   // Stuffing run of ones
	if (idx == 2'd3 && !cskip)
		append_bits(word, pos, sign, sign_len);
	size = pos;
endfunction

`endif

//--- testbench/tb_ecg_final_output.sv
/*
 * Testbench for the ECG output stage. Sends directed and LFSR groups into the
 * DUT, checks every output word and size against the reference model in order
 * and checks that each strobe comes out exactly two cycles later
 */

`timescale 1ns/1ns

module tb_ecg_final_output;

	import ecg_pkg::*;

	localparam int ECG_W      = ECG_W_DEFAULT;
	localparam int N_RANDOM   = 300;
	localparam int N_GROUPS   = 2 + 7 + 192 + 32 + N_RANDOM;
	localparam int TIMEOUT_NS = N_GROUPS * 2 * 20 + 2000;   // Random gaps at most double it

	`include "ecg_ref_model.svh"

	logic                    clk = 1'b0;
	logic                    rst;
	logic                    in_valid;
	logic                    data_active;
	logic                    group_skip;
	logic [1:0]              ecg_idx;
	logic                    component_skip;
	logic                    underflow_prevention;
	logic [BITS_REQ_W-1:0]   bits_req;
	logic [CPEC_CODE_W-1:0]  cpec_code;
	logic [VEC_PREFIX_W-1:0] vec_prefix;
	logic [2:0]              vec_prefix_size;
	logic [VEC_SUFFIX_W-1:0] vec_suffix;
	logic [2:0]              vec_suffix_size;
	logic [SIGN_W-1:0]       sign_bits;
	logic [SIGN_SIZE_W-1:0]  sign_size;
	logic [STUFF_SIZE_W-1:0] stuff_size;
	logic                    out_valid;
	logic [ECG_W-1:0]        encoded_ecg;
	ecg_size_t               ecg_size;

	logic [ECG_W-1:0] exp_word_q[$];   // Scoreboard holds one entry per strobed group
	int               exp_size_q[$];
	string            name_q[$];
	string            test_name;
	logic [1:0]       strobe_hist = '0;   // in_valid as seen by the last two edges
	int               n_out = 0;

	ecg_final_output #(.ECG_W(ECG_W)) DUT
	(
		.clk(clk), .rst(rst), .in_valid(in_valid), .data_active(data_active),
		.group_skip(group_skip), .ecg_idx(ecg_idx), .component_skip(component_skip),
		.underflow_prevention(underflow_prevention), .bits_req(bits_req),
		.cpec_code(cpec_code), .vec_prefix(vec_prefix), .vec_prefix_size(vec_prefix_size),
		.vec_suffix(vec_suffix), .vec_suffix_size(vec_suffix_size), .sign_bits(sign_bits),
		.sign_size(sign_size), .stuff_size(stuff_size), .out_valid(out_valid),
		.encoded_ecg(encoded_ecg), .ecg_size(ecg_size)
	);

	always #10 clk = ~clk;   // 20 ns period

	task automatic fail_value(input string test, input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("ERROR %s %s: expected %0h, actual %0h", test, what, exp, act);
		$display("*** FAILED ***");
		$fatal(1, "Value mismatch");
	endtask

	task automatic fail_plain(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "Check failed");
	endtask

	// ========================================
	// Stimulus
	// ========================================

	// Strobes the current fields in and records what should come out
	task automatic send_group();
		logic [ECG_W-1:0] w;
		int               s;
		expect_ecg(data_active, group_skip, ecg_idx, component_skip, underflow_prevention,
			bits_req, cpec_code, vec_prefix, vec_prefix_size, vec_suffix, vec_suffix_size,
			sign_bits, sign_size, stuff_size, w, s);
		exp_word_q.push_back(w);
		exp_size_q.push_back(s);
		name_q.push_back(test_name);
		in_valid = 1'b1;
		@(posedge clk);
		#2;
		in_valid = 1'b0;   // Caller may raise it again right away
	endtask

	task automatic idle_cycle();
		in_valid = 1'b0;
		@(posedge clk);
		#2;
	endtask

	// Random group whose stuffing and signs only fill what the data field leaves
	task automatic random_fields(input logic act);
		logic [ECG_W-1:0] w;
		int               dsize;
		int               room;
		data_active          = act;
		group_skip           = take_bits(3) == 0;
		bits_req             = take_bits(4) % 10;
		cpec_code            = take_bits(CPEC_CODE_W);
		vec_prefix           = take_bits(VEC_PREFIX_W);
		vec_prefix_size      = take_bits(3);
		vec_suffix           = take_bits(VEC_SUFFIX_W);
		vec_suffix_size      = take_bits(3);
		ecg_idx              = take_bits(2);
		component_skip       = take_bits(1);
		underflow_prevention = take_bits(1);
		sign_bits            = take_bits(SIGN_W);
		expect_ecg(act, group_skip, 2'd0, 1'b1, 1'b0, bits_req, cpec_code, vec_prefix,
			vec_prefix_size, vec_suffix, vec_suffix_size, 64'd0, 0, 0, w, dsize);
		room       = ECG_W - dsize;
		stuff_size = take_bits(5) % ((room < STUFF_MAX ? room : STUFF_MAX) + 1);
		room       = room - stuff_size;
		sign_size  = take_bits(4) % ((room < SIGN_W ? room : SIGN_W) + 1);
	endtask

	initial
	begin
		rst = 1'b1;
		in_valid = 1'b0;
		data_active = 1'b0;
		group_skip = 1'b0;
		ecg_idx = '0;
		component_skip = 1'b0;
		underflow_prevention = 1'b0;
		bits_req = '0;
		cpec_code = '0;
		vec_prefix = '0;
		vec_prefix_size = '0;
		vec_suffix = '0;
		vec_suffix_size = '0;
		sign_bits = '0;
		sign_size = '0;
		stuff_size = '0;
		test_name = "reset";
		repeat (4) @(posedge clk);
		#2;
		rst = 1'b0;
		idle_cycle();
		idle_cycle();   // Outputs must stay zero here

		test_name = "skip_idle";   // ecg_idx 0 keeps stuffing and signs out
		data_active = 1'b1;
		group_skip = 1'b1;
		send_group();
		data_active = 1'b0;
		send_group();

		test_name = "cpec";
		data_active = 1'b1;
		group_skip = 1'b0;
		for (int br = CPEC_MIN_BITS; br <= CPEC_MAX_BITS; br++)
		begin
			bits_req = br;
			cpec_code = take_bits(CPEC_CODE_W);
			send_group();
		end

		test_name = "vec";   // Every prefix and suffix size for bits_req 0 to 2
		for (int k = 0; k < 192; k++)
		begin
			bits_req = k / 64;
			vec_prefix_size = k[5:3];
			vec_suffix_size = k[2:0];
			vec_prefix = take_bits(VEC_PREFIX_W);
			vec_suffix = take_bits(VEC_SUFFIX_W);
			send_group();
		end

		test_name = "stuff_sign";
		for (int k = 0; k < 32; k++)
		begin
			random_fields(k[4]);
			ecg_idx = k[1:0];
			component_skip = k[2];
			underflow_prevention = k[3];
			send_group();
		end

		test_name = "random";   // Back-to-back strobes with an occasional gap
		repeat (N_RANDOM)
		begin
			if (take_bits(2) == 0)
				idle_cycle();
			random_fields(take_bits(3) != 0);
			send_group();
		end

		while (exp_size_q.size() != 0)
			idle_cycle();
		repeat (3) idle_cycle();   // Room for a stray extra output
		$display("*** PASSED ***");
		$finish;
	end

	// ========================================
	// Checking
	// ========================================

	always @(posedge clk)
		strobe_hist <= {strobe_hist[0], in_valid};

	// Outputs settle after the rising edge, so they are read at the falling one
	always @(negedge clk)
	begin
		if (!rst)
		begin
			assert (out_valid == strobe_hist[1])
			else fail_plain("out_valid did not come exactly two cycles after its strobe");
			if (!out_valid && n_out == 0)
			begin
				assert (encoded_ecg == '0) else fail_value(test_name, "word", 0, encoded_ecg);
				assert (ecg_size == '0) else fail_value(test_name, "size", 0, ecg_size);
			end
			if (out_valid)
			begin
				assert (exp_size_q.size() != 0)
				else fail_plain("An output came out with no group pending");
				assert (encoded_ecg == exp_word_q[0])
				else fail_value(name_q[0], "word", exp_word_q[0], encoded_ecg);
				assert (ecg_size == exp_size_q[0])
				else fail_value(name_q[0], "size", exp_size_q[0], ecg_size);
				exp_word_q.pop_front();
				exp_size_q.pop_front();
				name_q.pop_front();
				n_out++;
			end
		end
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("The run timed out before all groups came out");
		$display("*** FAILED ***");
		$fatal(1, "Timeout");
	end

endmodule

//--- project.f
+incdir+testbench
hw/ecg_pkg.sv
hw/ecg_input_stage.sv
hw/ecg_data_builder.sv
hw/ecg_packer.sv
hw/ecg_final_output.sv
testbench/tb_ecg_final_output.sv

//--- Bender.yml
package:
  name: ecg_final_output

sources:
  - files:
      - hw/ecg_pkg.sv
      - hw/ecg_input_stage.sv
      - hw/ecg_data_builder.sv
      - hw/ecg_packer.sv
      - hw/ecg_final_output.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_ecg_final_output.sv
